// ==== source/hpsdr_pkg.sv ====
// protocol constants assume EF FE framing with two subframes per data packet and a 1 kHz msec_pulse
`default_nettype none

package hpsdr_pkg;

  // packet framing bytes
  localparam logic [7:0] PREAMBLE0     = 8'hef;
  localparam logic [7:0] PREAMBLE1     = 8'hfe;
  localparam logic [7:0] CMD_DATA      = 8'h01;
  localparam logic [7:0] CMD_RUNSTOP   = 8'h04;
  localparam logic [7:0] DATA_ENDPOINT = 8'h02;
  localparam logic [7:0] SYNC_BYTE     = 8'h7f;

  // 63 groups of L1 L0 R1 R0 I1 I0 Q1 Q0 per subframe
  localparam logic [6:0] GROUPS_PER_SUBFRAME = 7'd63;

  // internal keyer enable lives in data bit 24 of address 0x0f
  localparam logic [5:0] CWX_ADDR       = 6'h0f;
  localparam logic [4:0] CWX_ENABLE_BIT = 5'd24;
  localparam logic [8:0] CWX_HANG_MS    = 9'd500;

  // sample FIFO entry is {user, last, data}
  localparam int FIFO_DEPTH   = 16;
  localparam int FIFO_ENTRY_W = 10;
  localparam int ENTRY_LAST   = 8;
  localparam int ENTRY_USER   = 9;

  // parser states, contiguous so the top code marks the end of the range
  localparam int STATE_W = 5;
  localparam logic [STATE_W-1:0] ST_START    = 5'd0;
  localparam logic [STATE_W-1:0] ST_PREAMBLE = 5'd1;
  localparam logic [STATE_W-1:0] ST_DECODE   = 5'd2;
  localparam logic [STATE_W-1:0] ST_RUNSTOP  = 5'd3;
  localparam logic [STATE_W-1:0] ST_ENDPOINT = 5'd4;
  localparam logic [STATE_W-1:0] ST_SEQNO3   = 5'd5;
  localparam logic [STATE_W-1:0] ST_SEQNO2   = 5'd6;
  localparam logic [STATE_W-1:0] ST_SEQNO1   = 5'd7;
  localparam logic [STATE_W-1:0] ST_SEQNO0   = 5'd8;
  localparam logic [STATE_W-1:0] ST_SYNC2    = 5'd9;
  localparam logic [STATE_W-1:0] ST_SYNC1    = 5'd10;
  localparam logic [STATE_W-1:0] ST_SYNC0    = 5'd11;
  localparam logic [STATE_W-1:0] ST_CMDCTRL  = 5'd12;
  localparam logic [STATE_W-1:0] ST_CMDDATA3 = 5'd13;
  localparam logic [STATE_W-1:0] ST_CMDDATA2 = 5'd14;
  localparam logic [STATE_W-1:0] ST_CMDDATA1 = 5'd15;
  localparam logic [STATE_W-1:0] ST_CMDDATA0 = 5'd16;
  localparam logic [STATE_W-1:0] ST_PUSHL1   = 5'd17;
  localparam logic [STATE_W-1:0] ST_PUSHL0   = 5'd18;
  localparam logic [STATE_W-1:0] ST_PUSHR1   = 5'd19;
  localparam logic [STATE_W-1:0] ST_PUSHR0   = 5'd20;
  localparam logic [STATE_W-1:0] ST_PUSHI1   = 5'd21;
  localparam logic [STATE_W-1:0] ST_PUSHI0   = 5'd22;
  localparam logic [STATE_W-1:0] ST_PUSHQ1   = 5'd23;
  localparam logic [STATE_W-1:0] ST_PUSHQ0   = 5'd24;

endpackage

`default_nettype wire

// ==== source/ds_unpacker.sv ====
// parses the PC byte stream with no back-pressure; push strobes are combinational on accepted bytes
`default_nettype none

module ds_unpacker (
  input  wire         clk,
  input  wire         reset,
  input  wire  [ 7:0] ds_stream,
  input  wire         ds_stream_valid,
  input  wire         msec_pulse,
  input  wire  [ 5:0] cmd_addr,
  input  wire  [31:0] cmd_data,
  input  wire         cmd_rqst,
  output logic        run,
  output logic        wide_spectrum,
  output logic [ 5:0] ds_cmd_addr,
  output logic [31:0] ds_cmd_data,
  output logic        ds_cmd_cnt,
  output logic        ds_cmd_resprqst,
  output logic        ds_cmd_ptt,
  output logic [ 7:0] byte_data,
  output logic        byte_last,
  output logic        byte_user,
  output logic        lr_push,
  output logic        iq_push
);

  logic [hpsdr_pkg::STATE_W-1:0] state;
  logic [hpsdr_pkg::STATE_W-1:0] state_next;
  logic [ 6:0] group_cnt;
  logic [ 6:0] group_next;
  logic        second_sub;
  logic        second_next;

  logic        run_next;
  logic        wide_next;
  logic [ 5:0] addr_next;
  logic [31:0] data_next;
  logic        cnt_next;
  logic        resprqst_next;
  logic        ptt_next;

  logic        cwx_enable;
  logic        cwx_pushiq;
  logic        cwx_pushiq_next;
  logic [ 1:0] cwx_saved;
  logic [ 1:0] cwx_saved_next;
  logic [ 8:0] hang_cnt;
  logic        hang_running;
  logic        iq_gate;

  assign byte_data    = ds_stream;
  assign hang_running = (hang_cnt != 9'd0);
  assign iq_gate      = ds_cmd_ptt | cwx_pushiq;

  always_ff @(posedge clk) begin
    if (reset) begin
      state           <= hpsdr_pkg::ST_START;
      group_cnt       <= 7'd0;
      second_sub      <= 1'b0;
      run             <= 1'b0;
      wide_spectrum   <= 1'b0;
      ds_cmd_cnt      <= 1'b0;
      ds_cmd_resprqst <= 1'b0;
      ds_cmd_ptt      <= 1'b0;
      cwx_pushiq      <= 1'b0;
      cwx_saved       <= 2'b00;
    end else if (ds_stream_valid) begin
      state           <= state_next;
      group_cnt       <= group_next;
      second_sub      <= second_next;
      run             <= run_next;
      wide_spectrum   <= wide_next;
      ds_cmd_cnt      <= cnt_next;
      ds_cmd_resprqst <= resprqst_next;
      ds_cmd_ptt      <= ptt_next;
      cwx_pushiq      <= cwx_pushiq_next;
      cwx_saved       <= cwx_saved_next;
    end
  end

  always_ff @(posedge clk) begin
    if (ds_stream_valid) begin
      ds_cmd_addr <= addr_next;
      ds_cmd_data <= data_next;
    end
  end

  always_comb begin
    state_next      = hpsdr_pkg::ST_START;
    group_next      = group_cnt;
    second_next     = second_sub;
    run_next        = run;
    wide_next       = wide_spectrum;
    addr_next       = ds_cmd_addr;
    data_next       = ds_cmd_data;
    cnt_next        = ds_cmd_cnt;
    resprqst_next   = ds_cmd_resprqst;
    ptt_next        = ds_cmd_ptt;
    cwx_pushiq_next = cwx_pushiq;
    cwx_saved_next  = cwx_saved;
    lr_push         = 1'b0;
    iq_push         = 1'b0;
    byte_last       = 1'b0;
    byte_user       = 1'b0;

    case (state)
      hpsdr_pkg::ST_START: begin
        group_next  = 7'd0;
        second_next = 1'b0;
        if (ds_stream == hpsdr_pkg::PREAMBLE0) state_next = hpsdr_pkg::ST_PREAMBLE;
      end
      hpsdr_pkg::ST_PREAMBLE: begin
        if (ds_stream == hpsdr_pkg::PREAMBLE1) state_next = hpsdr_pkg::ST_DECODE;
      end
      hpsdr_pkg::ST_DECODE: begin
        if (ds_stream == hpsdr_pkg::CMD_DATA) begin
          state_next = hpsdr_pkg::ST_ENDPOINT;
        end else if (ds_stream == hpsdr_pkg::CMD_RUNSTOP) begin
          state_next = hpsdr_pkg::ST_RUNSTOP;
        end
      end
      hpsdr_pkg::ST_RUNSTOP: begin
        run_next  = ds_stream[0];
        wide_next = ds_stream[1];
      end
      hpsdr_pkg::ST_ENDPOINT: begin
        if (ds_stream == hpsdr_pkg::DATA_ENDPOINT) state_next = hpsdr_pkg::ST_SEQNO3;
      end
      // sequence number is not checked
      hpsdr_pkg::ST_SEQNO3: state_next = hpsdr_pkg::ST_SEQNO2;
      hpsdr_pkg::ST_SEQNO2: state_next = hpsdr_pkg::ST_SEQNO1;
      hpsdr_pkg::ST_SEQNO1: state_next = hpsdr_pkg::ST_SEQNO0;
      hpsdr_pkg::ST_SEQNO0: state_next = hpsdr_pkg::ST_SYNC2;
      hpsdr_pkg::ST_SYNC2: begin
        if (ds_stream == hpsdr_pkg::SYNC_BYTE) state_next = hpsdr_pkg::ST_SYNC1;
      end
      hpsdr_pkg::ST_SYNC1: begin
        if (ds_stream == hpsdr_pkg::SYNC_BYTE) state_next = hpsdr_pkg::ST_SYNC0;
      end
      hpsdr_pkg::ST_SYNC0: begin
        if (ds_stream == hpsdr_pkg::SYNC_BYTE) state_next = hpsdr_pkg::ST_CMDCTRL;
      end
      hpsdr_pkg::ST_CMDCTRL: begin
        resprqst_next = ds_stream[7];
        addr_next     = ds_stream[6:1];
        ptt_next      = ds_stream[0];
        state_next    = hpsdr_pkg::ST_CMDDATA3;
      end
      hpsdr_pkg::ST_CMDDATA3: begin
        // ptt here is already the value from this subframe's control byte
        cwx_pushiq_next = ~ds_cmd_ptt & cwx_enable & ((|cwx_saved) | hang_running);
        data_next       = {ds_stream, ds_cmd_data[23:0]};
        state_next      = hpsdr_pkg::ST_CMDDATA2;
      end
      hpsdr_pkg::ST_CMDDATA2: begin
        data_next  = {ds_cmd_data[31:24], ds_stream, ds_cmd_data[15:0]};
        state_next = hpsdr_pkg::ST_CMDDATA1;
      end
      hpsdr_pkg::ST_CMDDATA1: begin
        data_next  = {ds_cmd_data[31:16], ds_stream, ds_cmd_data[7:0]};
        state_next = hpsdr_pkg::ST_CMDDATA0;
      end
      hpsdr_pkg::ST_CMDDATA0: begin
        data_next  = {ds_cmd_data[31:8], ds_stream};
        cnt_next   = ~ds_cmd_cnt;
        state_next = hpsdr_pkg::ST_PUSHL1;
      end
      hpsdr_pkg::ST_PUSHL1: begin
        lr_push    = ds_stream_valid;
        state_next = hpsdr_pkg::ST_PUSHL0;
      end
      hpsdr_pkg::ST_PUSHL0: begin
        lr_push    = ds_stream_valid;
        state_next = hpsdr_pkg::ST_PUSHR1;
      end
      hpsdr_pkg::ST_PUSHR1: begin
        lr_push    = ds_stream_valid;
        state_next = hpsdr_pkg::ST_PUSHR0;
      end
      hpsdr_pkg::ST_PUSHR0: begin
        lr_push    = ds_stream_valid;
        byte_last  = 1'b1;
        state_next = hpsdr_pkg::ST_PUSHI1;
      end
      hpsdr_pkg::ST_PUSHI1: begin
        iq_push    = ds_stream_valid & iq_gate;
        byte_user  = ds_cmd_ptt;
        state_next = hpsdr_pkg::ST_PUSHI0;
      end
      hpsdr_pkg::ST_PUSHI0: begin
        // I0 still carries bit 0 saved from the previous group
        iq_push        = ds_stream_valid & iq_gate;
        byte_user      = cwx_saved[0];
        cwx_saved_next = {ds_stream[3], ds_stream[0]};
        state_next     = hpsdr_pkg::ST_PUSHQ1;
      end
      hpsdr_pkg::ST_PUSHQ1: begin
        iq_push    = ds_stream_valid & iq_gate;
        byte_user  = cwx_saved[1];
        state_next = hpsdr_pkg::ST_PUSHQ0;
      end
      hpsdr_pkg::ST_PUSHQ0: begin
        iq_push         = ds_stream_valid & iq_gate;
        byte_last       = 1'b1;
        cwx_pushiq_next = ~ds_cmd_ptt & cwx_enable & ((|cwx_saved) | hang_running);
        if (group_cnt == hpsdr_pkg::GROUPS_PER_SUBFRAME - 7'd1) begin
          group_next  = 7'd0;
          second_next = ~second_sub;
          state_next  = second_sub ? hpsdr_pkg::ST_START : hpsdr_pkg::ST_SYNC2;
        end else begin
          group_next = group_cnt + 7'd1;
          state_next = hpsdr_pkg::ST_PUSHL1;
        end
      end
      default: state_next = hpsdr_pkg::ST_START;
    endcase
  end

  // keyer enable written from the card's command bus
  always_ff @(posedge clk) begin
    if (reset) begin
      cwx_enable <= 1'b0;
    end else if (cmd_rqst && cmd_addr == hpsdr_pkg::CWX_ADDR) begin
      cwx_enable <= cmd_data[hpsdr_pkg::CWX_ENABLE_BIT];
    end
  end

  // hang keeps IQ flowing between CW elements
  always_ff @(posedge clk) begin
    if (reset || ds_cmd_ptt || !cwx_enable) begin
      hang_cnt <= 9'd0;
    end else if (|cwx_saved) begin
      hang_cnt <= hpsdr_pkg::CWX_HANG_MS;
    end else if (hang_running && msec_pulse) begin
      hang_cnt <= hang_cnt - 9'd1;
    end
  end

  state_in_range: assert property (@(posedge clk) disable iff (reset)
    state <= hpsdr_pkg::ST_PUSHQ0)
    else $error("ds_unpacker state out of range");

endmodule

`default_nettype wire

// ==== source/sample_fifo.sv ====
// show-ahead FIFO, DEPTH must be a power of two; a push while full is lost and latches overflow
`default_nettype none

module sample_fifo #(
  parameter int DEPTH = hpsdr_pkg::FIFO_DEPTH
) (
  input  wire                                 clk,
  input  wire                                 reset,
  input  wire                                 push,
  input  wire  [hpsdr_pkg::FIFO_ENTRY_W-1:0] push_entry,
  input  wire                                 pop,
  output logic [hpsdr_pkg::FIFO_ENTRY_W-1:0] head_entry,
  output logic                                empty,
  output logic                                overflow
);

  localparam int AW = $clog2(DEPTH);

  logic [hpsdr_pkg::FIFO_ENTRY_W-1:0] mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          full;
  logic          do_push;
  logic          do_pop;

  assign full       = (count == DEPTH[AW:0]);
  assign empty      = (count == '0);
  assign do_push    = push & ~full;
  assign do_pop     = pop & ~empty;
  assign head_entry = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_entry;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // sticky until reset
      if (push && full) overflow <= 1'b1;
    end
  end

  // the consumer only pops what it sees at the head
  no_pop_when_empty: assert property (@(posedge clk) disable iff (reset)
    pop |-> !empty)
    else $error("sample_fifo popped while empty");

endmodule

`default_nettype wire

// ==== source/sample_assembler.sv ====
// drains one byte per cycle; pair_data and pair_user are only meaningful while pair_valid is high
`default_nettype none

module sample_assembler (
  input  wire                                 clk,
  input  wire                                 reset,
  input  wire  [hpsdr_pkg::FIFO_ENTRY_W-1:0] head_entry,
  input  wire                                 empty,
  output logic                                pop,
  output logic [31:0]                         pair_data,
  output logic [ 2:0]                         pair_user,
  output logic                                pair_valid,
  output logic                                framing_error
);

  logic [1:0] byte_cnt;
  logic [7:0] head_data;
  logic       head_last;
  logic       head_user;

  assign head_data = head_entry[7:0];
  assign head_last = head_entry[hpsdr_pkg::ENTRY_LAST];
  assign head_user = head_entry[hpsdr_pkg::ENTRY_USER];
  assign pop       = ~empty;

  // first byte ends up in the top, user of byte 1 ends up in pair_user[2]
  always_ff @(posedge clk) begin
    if (pop) begin
      pair_data <= {pair_data[23:0], head_data};
      if (byte_cnt != 2'd3) pair_user <= {pair_user[1:0], head_user};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      byte_cnt      <= 2'd0;
      pair_valid    <= 1'b0;
      framing_error <= 1'b0;
    end else begin
      pair_valid    <= 1'b0;
      framing_error <= 1'b0;
      if (pop) begin
        if (byte_cnt == 2'd3) begin
          byte_cnt <= 2'd0;
          if (head_last) begin
            pair_valid <= 1'b1;
          end else begin
            framing_error <= 1'b1;
          end
        end else if (head_last) begin
          // early last, resync on the next byte
          byte_cnt      <= 2'd0;
          framing_error <= 1'b1;
        end else begin
          byte_cnt <= byte_cnt + 2'd1;
        end
      end
    end
  end

  valid_or_error: assert property (@(posedge clk) disable iff (reset)
    !(pair_valid && framing_error))
    else $error("sample_assembler flagged a pair and an error together");

endmodule

`default_nettype wire

// ==== source/ds_frontend.sv ====
// downstream front end; the PC stream cannot be stalled and sample output latency varies
`default_nettype none

module ds_frontend (
  input  wire         clk,
  input  wire         reset,
  input  wire  [ 7:0] ds_stream,
  input  wire         ds_stream_valid,
  input  wire         msec_pulse,
  input  wire  [ 5:0] cmd_addr,
  input  wire  [31:0] cmd_data,
  input  wire         cmd_rqst,
  output wire         run,
  output wire         wide_spectrum,
  output wire  [ 5:0] ds_cmd_addr,
  output wire  [31:0] ds_cmd_data,
  output wire         ds_cmd_cnt,
  output wire         ds_cmd_resprqst,
  output wire         ds_cmd_ptt,
  output wire  [31:0] lr_pair_data,
  output wire         lr_pair_valid,
  output wire  [31:0] iq_pair_data,
  output wire  [ 2:0] iq_pair_user,
  output wire         iq_pair_valid,
  output wire         framing_error,
  output wire         lr_overflow,
  output wire         iq_overflow
);

  wire [7:0] byte_data;
  wire       byte_last;
  wire       byte_user;
  wire       lr_push;
  wire       iq_push;
  wire [hpsdr_pkg::FIFO_ENTRY_W-1:0] lr_head;
  wire [hpsdr_pkg::FIFO_ENTRY_W-1:0] iq_head;
  wire       lr_empty;
  wire       iq_empty;
  wire       lr_pop;
  wire       iq_pop;
  wire       lr_framing_error;
  wire       iq_framing_error;

  assign framing_error = lr_framing_error | iq_framing_error;

  ds_unpacker u_unpacker (
    .clk             (clk),
    .reset           (reset),
    .ds_stream       (ds_stream),
    .ds_stream_valid (ds_stream_valid),
    .msec_pulse      (msec_pulse),
    .cmd_addr        (cmd_addr),
    .cmd_data        (cmd_data),
    .cmd_rqst        (cmd_rqst),
    .run             (run),
    .wide_spectrum   (wide_spectrum),
    .ds_cmd_addr     (ds_cmd_addr),
    .ds_cmd_data     (ds_cmd_data),
    .ds_cmd_cnt      (ds_cmd_cnt),
    .ds_cmd_resprqst (ds_cmd_resprqst),
    .ds_cmd_ptt      (ds_cmd_ptt),
    .byte_data       (byte_data),
    .byte_last       (byte_last),
    .byte_user       (byte_user),
    .lr_push         (lr_push),
    .iq_push         (iq_push)
  );

  // both FIFOs see the same byte bus, the push strobe picks one
  sample_fifo u_lr_fifo (
    .clk        (clk),
    .reset      (reset),
    .push       (lr_push),
    .push_entry ({byte_user, byte_last, byte_data}),
    .pop        (lr_pop),
    .head_entry (lr_head),
    .empty      (lr_empty),
    .overflow   (lr_overflow)
  );

  sample_fifo u_iq_fifo (
    .clk        (clk),
    .reset      (reset),
    .push       (iq_push),
    .push_entry ({byte_user, byte_last, byte_data}),
    .pop        (iq_pop),
    .head_entry (iq_head),
    .empty      (iq_empty),
    .overflow   (iq_overflow)
  );

  sample_assembler u_lr_asm (
    .clk           (clk),
    .reset         (reset),
    .head_entry    (lr_head),
    .empty         (lr_empty),
    .pop           (lr_pop),
    .pair_data     (lr_pair_data),
    .pair_user     (),
    .pair_valid    (lr_pair_valid),
    .framing_error (lr_framing_error)
  );

  sample_assembler u_iq_asm (
    .clk           (clk),
    .reset         (reset),
    .head_entry    (iq_head),
    .empty         (iq_empty),
    .pop           (iq_pop),
    .pair_data     (iq_pair_data),
    .pair_user     (iq_pair_user),
    .pair_valid    (iq_pair_valid),
    .framing_error (iq_framing_error)
  );

endmodule

`default_nettype wire

// ==== test/tb_ds_frontend.sv ====
// msec_pulse rides on every 8th byte of a data packet, so hang time is counted in accepted bytes
`default_nettype none

module tb_ds_frontend;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PKT_LEN = 1032;
  localparam int SUB_LEN = 512;

  logic        clk;
  logic        reset;
  logic [ 7:0] ds_stream;
  logic        ds_stream_valid;
  logic        msec_pulse;
  logic [ 5:0] cmd_addr;
  logic [31:0] cmd_data;
  logic        cmd_rqst;
  wire         run;
  wire         wide_spectrum;
  wire  [ 5:0] ds_cmd_addr;
  wire  [31:0] ds_cmd_data;
  wire         ds_cmd_cnt;
  wire         ds_cmd_resprqst;
  wire         ds_cmd_ptt;
  wire  [31:0] lr_pair_data;
  wire         lr_pair_valid;
  wire  [31:0] iq_pair_data;
  wire  [ 2:0] iq_pair_user;
  wire         iq_pair_valid;
  wire         framing_error;
  wire         lr_overflow;
  wire         iq_overflow;

  // stream items are {cmd write, msec, byte}
  logic [ 9:0] stim_q[$];
  logic [ 1:0] level_q[$];
  logic [31:0] lr_exp[$];
  logic [34:0] iq_exp[$];
  logic [39:0] cmd_exp[$];
  logic [ 7:0] pkt [PKT_LEN];

  // reference state after the last modeled byte
  logic        m_run = 1'b0;
  logic        m_wide = 1'b0;
  logic        m_ptt = 1'b0;
  logic        m_en = 1'b0;
  logic        m_pushiq = 1'b0;
  logic [ 1:0] m_saved = 2'b00;
  logic [ 8:0] m_hang = 9'd0;

  int          seed = 43032;
  int          value_errors = 0;
  int          other_errors = 0;
  int          cycle_limit = 0;
  int          cycles = 0;
  logic [ 1:0] cur_level = 2'b00;
  logic        last_cnt = 1'b0;

  ds_frontend u_dut (
    .clk             (clk),
    .reset           (reset),
    .ds_stream       (ds_stream),
    .ds_stream_valid (ds_stream_valid),
    .msec_pulse      (msec_pulse),
    .cmd_addr        (cmd_addr),
    .cmd_data        (cmd_data),
    .cmd_rqst        (cmd_rqst),
    .run             (run),
    .wide_spectrum   (wide_spectrum),
    .ds_cmd_addr     (ds_cmd_addr),
    .ds_cmd_data     (ds_cmd_data),
    .ds_cmd_cnt      (ds_cmd_cnt),
    .ds_cmd_resprqst (ds_cmd_resprqst),
    .ds_cmd_ptt      (ds_cmd_ptt),
    .lr_pair_data    (lr_pair_data),
    .lr_pair_valid   (lr_pair_valid),
    .iq_pair_data    (iq_pair_data),
    .iq_pair_user    (iq_pair_user),
    .iq_pair_valid   (iq_pair_valid),
    .framing_error   (framing_error),
    .lr_overflow     (lr_overflow),
    .iq_overflow     (iq_overflow)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [7:0] random_byte();
    logic [31:0] r;
    r = $random(seed);
    return r[7:0];
  endfunction

  // walks pkt byte by byte, queues the bytes and everything the DUT should produce
  function automatic void model_packet(input int len);
    logic [7:0] b;
    logic       is_data;
    logic       msec;
    logic       o_ptt;
    logic       o_push;
    logic [1:0] o_saved;
    logic [8:0] o_hang;
    logic       prev0;
    int         p;
    int         j;
    is_data = (pkt[2] == hpsdr_pkg::CMD_DATA);
    for (int i = 0; i < len; i++) begin
      b       = pkt[i];
      o_ptt   = m_ptt;
      o_push  = m_pushiq;
      o_saved = m_saved;
      o_hang  = m_hang;
      msec    = is_data && (i % 8 == 7);
      if (o_ptt || !m_en) m_hang = 9'd0;
      else if (o_saved != 2'b00) m_hang = hpsdr_pkg::CWX_HANG_MS;
      else if (o_hang != 9'd0 && msec) m_hang = o_hang - 9'd1;
      if (!is_data) begin
        if (i == 3) begin
          m_run  = b[0];
          m_wide = b[1];
        end
      end else if (i >= 8) begin
        p = (i - 8) % SUB_LEN;
        if (p == 3) begin
          m_ptt = b[0];
        end else if (p == 4) begin
          m_pushiq = !o_ptt && m_en && (o_saved != 2'b00 || o_hang != 9'd0);
        end else if (p == 7) begin
          cmd_exp.push_back({pkt[i-4], pkt[i-3], pkt[i-2], pkt[i-1], b});
        end else if (p >= 8) begin
          j = (p - 8) % 8;
          if (j == 3) lr_exp.push_back({pkt[i-3], pkt[i-2], pkt[i-1], b});
          if (j == 5) begin
            prev0   = o_saved[0];
            m_saved = {b[3], b[0]};
          end
          if (j == 7) begin
            if (o_ptt || o_push) begin
              iq_exp.push_back({m_ptt, prev0, m_saved[1], pkt[i-3], pkt[i-2], pkt[i-1], b});
            end
            m_pushiq = !m_ptt && m_en && (m_saved != 2'b00 || o_hang != 9'd0);
          end
        end
      end
      stim_q.push_back({1'b0, msec, b});
      level_q.push_back({m_run, m_wide});
    end
  endfunction

  // never a preamble byte, so the parser stays idle
  task automatic add_garbage(input int n);
    logic [7:0] b;
    for (int k = 0; k < n; k++) begin
      b = random_byte();
      if (b == hpsdr_pkg::PREAMBLE0) b = 8'h00;
      stim_q.push_back({2'b00, b});
      level_q.push_back({m_run, m_wide});
    end
  endtask

  task automatic send_runstop(input logic [1:0] bits);
    pkt[0] = hpsdr_pkg::PREAMBLE0;
    pkt[1] = hpsdr_pkg::PREAMBLE1;
    pkt[2] = hpsdr_pkg::CMD_RUNSTOP;
    pkt[3] = random_byte();
    pkt[3][1:0] = bits;
    model_packet(4);
  endtask

  // groups below key_groups carry a CW bit in I0, later ones carry none
  task automatic send_data(input logic ptt, input int key_groups);
    int i;
    pkt[0] = hpsdr_pkg::PREAMBLE0;
    pkt[1] = hpsdr_pkg::PREAMBLE1;
    pkt[2] = hpsdr_pkg::CMD_DATA;
    pkt[3] = hpsdr_pkg::DATA_ENDPOINT;
    for (int k = 4; k < 8; k++) pkt[k] = random_byte();
    i = 8;
    for (int s = 0; s < 2; s++) begin
      for (int k = 0; k < 3; k++) pkt[i + k] = hpsdr_pkg::SYNC_BYTE;
      pkt[i + 3] = random_byte();
      pkt[i + 3][0] = ptt;
      for (int k = 4; k < 8; k++) pkt[i + k] = random_byte();
      i = i + 8;
      for (int g = 0; g < 63; g++) begin
        for (int k = 0; k < 8; k++) begin
          pkt[i] = random_byte();
          if (k == 5 && s * 63 + g < key_groups) begin
            pkt[i][0] = 1'b1;
          end else if (k == 5) begin
            pkt[i][0] = 1'b0;
            pkt[i][3] = 1'b0;
          end
          i = i + 1;
        end
      end
    end
    model_packet(PKT_LEN);
  endtask

  task automatic write_cwx_enable(input logic en);
    m_en = en;
    stim_q.push_back({1'b1, 1'b0, 7'd0, en});
  endtask

  initial begin
    logic [ 9:0] item;
    logic [31:0] r;
    reset           = 1'b1;
    ds_stream       = 8'h00;
    ds_stream_valid = 1'b0;
    msec_pulse      = 1'b0;
    cmd_addr        = 6'd0;
    cmd_data        = 32'd0;
    cmd_rqst        = 1'b0;
    add_garbage(6);
    send_runstop(2'b01);
    add_garbage(9);
    send_runstop(2'b11);
    add_garbage(4);
    send_data(1'b1, 64);
    add_garbage(5);
    send_data(1'b0, 20);
    add_garbage(3);
    write_cwx_enable(1'b1);
    add_garbage(4);
    send_data(1'b0, 40);
    // the hang runs out part way through the last of these
    for (int n = 0; n < 4; n++) begin
      add_garbage(2);
      send_data(1'b0, 0);
    end
    send_runstop(2'b10);
    add_garbage(8);
    cycle_limit = 3 * stim_q.size() + 200;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    while (stim_q.size() > 0) begin
      @(posedge clk);
      cmd_rqst <= 1'b0;
      r = $random(seed);
      if (r[1:0] == 2'b00) begin
        ds_stream_valid <= 1'b0;
        msec_pulse      <= 1'b0;
      end else begin
        item = stim_q.pop_front();
        ds_stream       <= item[7:0];
        ds_stream_valid <= !item[9];
        msec_pulse      <= item[8];
        if (item[9]) begin
          cmd_rqst <= 1'b1;
          cmd_addr <= hpsdr_pkg::CWX_ADDR;
          cmd_data <= {7'd0, item[0], 24'd0};
        end
      end
    end
    @(posedge clk);
    ds_stream_valid <= 1'b0;
    msec_pulse      <= 1'b0;
    cmd_rqst        <= 1'b0;
    while (lr_exp.size() + iq_exp.size() + cmd_exp.size() != 0) @(posedge clk);
    repeat (20) @(posedge clk);
    assert (!lr_overflow) else begin
      $display("the LR FIFO overflowed");
      other_errors++;
    end
    assert (!iq_overflow) else begin
      $display("the IQ FIFO overflowed");
      other_errors++;
    end
    $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // outputs are sampled half a cycle after the edge that moved them
  always @(negedge clk) begin : compare
    logic [39:0] ce;
    logic [34:0] ie;
    logic [31:0] le;
    if (!reset) begin
      assert (run == cur_level[1]) else begin
        $display("Fail run: got %h expected %h", run, cur_level[1]);
        value_errors++;
      end
      assert (wide_spectrum == cur_level[0]) else begin
        $display("Fail wide_spectrum: got %h expected %h", wide_spectrum, cur_level[0]);
        value_errors++;
      end
      if (ds_stream_valid && level_q.size() != 0) cur_level = level_q.pop_front();
      if (ds_cmd_cnt != last_cnt) begin
        last_cnt = ds_cmd_cnt;
        assert (cmd_exp.size() != 0) else begin
          $display("ds_cmd_cnt toggled with no subframe command expected");
          other_errors++;
        end
        if (cmd_exp.size() != 0) begin
          ce = cmd_exp.pop_front();
          assert (ds_cmd_resprqst == ce[39]) else begin
            $display("Fail ds_cmd_resprqst: got %h expected %h", ds_cmd_resprqst, ce[39]);
            value_errors++;
          end
          assert (ds_cmd_addr == ce[38:33]) else begin
            $display("Fail ds_cmd_addr: got %h expected %h", ds_cmd_addr, ce[38:33]);
            value_errors++;
          end
          assert (ds_cmd_ptt == ce[32]) else begin
            $display("Fail ds_cmd_ptt: got %h expected %h", ds_cmd_ptt, ce[32]);
            value_errors++;
          end
          assert (ds_cmd_data == ce[31:0]) else begin
            $display("Fail ds_cmd_data: got %h expected %h", ds_cmd_data, ce[31:0]);
            value_errors++;
          end
        end
      end
      if (lr_pair_valid) begin
        assert (lr_exp.size() != 0) else begin
          $display("an LR pair arrived when none was expected");
          other_errors++;
        end
        if (lr_exp.size() != 0) begin
          le = lr_exp.pop_front();
          assert (lr_pair_data == le) else begin
            $display("Fail lr_pair_data: got %h expected %h", lr_pair_data, le);
            value_errors++;
          end
        end
      end
      if (iq_pair_valid) begin
        assert (iq_exp.size() != 0) else begin
          $display("an IQ pair arrived when none was expected");
          other_errors++;
        end
        if (iq_exp.size() != 0) begin
          ie = iq_exp.pop_front();
          assert (iq_pair_data == ie[31:0]) else begin
            $display("Fail iq_pair_data: got %h expected %h", iq_pair_data, ie[31:0]);
            value_errors++;
          end
          assert (iq_pair_user == ie[34:32]) else begin
            $display("Fail iq_pair_user: got %h expected %h", iq_pair_user, ie[34:32]);
            value_errors++;
          end
        end
      end
      assert (!framing_error) else begin
        $display("an assembler reported a framing error");
        other_errors++;
      end
    end
  end

  initial begin
    wait (cycle_limit > 0);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles with %0d LR pairs, %0d IQ pairs and %0d commands missing",
             cycles, lr_exp.size(), iq_exp.size(), cmd_exp.size());
    other_errors++;
    $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/hpsdr_pkg.sv
source/ds_unpacker.sv
source/sample_fifo.sv
source/sample_assembler.sv
source/ds_frontend.sv
test/tb_ds_frontend.sv

// ==== Bender.yml ====
package:
  name: ds_frontend

sources:
  - source/hpsdr_pkg.sv
  - source/ds_unpacker.sv
  - source/sample_fifo.sv
  - source/sample_assembler.sv
  - source/ds_frontend.sv
  - target: test
    files:
      - test/tb_ds_frontend.sv
